// File: vlog.f
+incdir+bench
hw/ring_pkg.sv
hw/op_alu_dec.sv
hw/op_mem_dec.sv
hw/op_flow_dec.sv
hw/hive_op_data.sv
bench/tb_hive_op_data.sv

// File: Bender.yml
package:
  name: hive_op_data

sources:
  - target: any(rtl, test)
    files:
      - hw/ring_pkg.sv
      - hw/op_alu_dec.sv
      - hw/op_mem_dec.sv
      - hw/op_flow_dec.sv
      - hw/hive_op_data.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_hive_op_data.sv

// File: bench/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// one full set of decoder outputs
typedef struct packed {
	ring_pkg::alu_ctl_t alu;
	logic [ring_pkg::alu_w-1:0] im_alu;
	logic imda;
	logic [ring_pkg::stk_w-1:0] a_sel;
	logic [ring_pkg::stk_w-1:0] b_sel;
	ring_pkg::mem_ctl_t mem;
	logic mem_rd;
	logic reg_rd;
	logic reg_wr;
	logic [ring_pkg::pc_w-1:0] im_mem;
	ring_pkg::stk_ctl_t stk;
	logic op_er;
} dec_out_t;

// named opcode bytes, one range per class block
function automatic logic kept_op(input logic [7:0] b);
	return b inside {[8'h00:8'h0c], [8'h10:8'h28], [8'h30:8'h3e], [8'h40:8'h51], [8'h60:8'h63]};
endfunction

// expected outputs one cycle after word w with flags clt and irq
function automatic dec_out_t predict(input logic [31:0] w, input logic clt, input logic irq);
	dec_out_t e;
	logic [7:0] b;
	logic [7:0] i8;
	logic [15:0] i16;
	logic [7:0] m;  // lit hlf sgn byt wr, then rd rrd rwr
	b = w[7:0];
	i8 = w[23:16];
	i16 = w[31:16];
	e = '0;
	e.a_sel = w[10:8];  // selectors follow word
	e.b_sel = w[14:12];
	e.im_alu = {{24{i8[7]}}, i8};  // im8 sign extended
	e.stk.sa = w[10:8];
	e.stk.sb = w[14:12];
	e.stk.pa = w[11];
	e.stk.pb = w[15];
	if (clt) begin
		e.stk.cls = '1;  // clear beats irq
		e.stk.pa = 1'b0;
		e.stk.pb = 1'b0;
		return e;
	end
	if (irq) begin
		e.alu.pc_sel = 1'b1;  // pc to top stack
		e.stk.psh = 1'b1;
		e.stk.sa = 3'(ring_pkg::stacks - 1);
		e.stk.pa = 1'b0;
		e.stk.pb = 1'b0;
		return e;
	end
	if (!kept_op(b)) begin
		e.op_er = 1'b1;  // nothing else moves
		return e;
	end
	if (b inside {[8'h00:8'h06]}) begin  // nop hlt pop cls im jumps
		e.stk.pa = 1'b0;
		e.stk.pb = 1'b0;
	end
	if (b == 8'h02)
		e.stk.pop = w[15:8];
	if (b == 8'h03)
		e.stk.cls = w[15:8];
	e.stk.psh = b inside {[8'h0a:8'h0c], [8'h10:8'h28], [8'h30:8'h3a],
		[8'h40:8'h4c], 8'h4e, 8'h50, [8'h60:8'h63]};  // result lands on sa
	if (b inside {[8'h40:8'h4a], [8'h60:8'h63]}) begin
		e.imda = 1'b1;  // im alu forms
		e.a_sel = w[14:12];
	end
	if (b inside {8'h50, 8'h51})
		e.imda = 1'b1;  // reg address from im
	if (b inside {[8'h60:8'h63]})
		e.im_alu = {{16{i16[15]}}, i16};
	e.alu.pc_sel = b inside {[8'h0a:8'h0c], 8'h4b};
	e.alu.as_sel = b inside {[8'h10:8'h1b], [8'h40:8'h43], 8'h60};
	e.alu.ms_sel = b inside {[8'h1c:8'h23], [8'h44:8'h47]};
	if (b inside {[8'h10:8'h1b]})
		e.alu.as_op = ring_pkg::as_op_t'(4'(b - 8'h10));  // table order
	if (b inside {[8'h1c:8'h23]})
		e.alu.ms_op = ring_pkg::ms_op_t'(3'(b - 8'h1c));
	case (b)
		8'h25 : e.alu.lg_op = ring_pkg::lg_not;
		8'h26, 8'h48, 8'h61 : e.alu.lg_op = ring_pkg::lg_and;
		8'h27, 8'h49, 8'h62 : e.alu.lg_op = ring_pkg::lg_orr;
		8'h28, 8'h4a, 8'h63 : e.alu.lg_op = ring_pkg::lg_xor;
		8'h41, 8'h60 : e.alu.as_op = ring_pkg::as_add_s;
		8'h42 : e.alu.as_op = ring_pkg::as_sub_u;
		8'h43 : e.alu.as_op = ring_pkg::as_sub_s;
		8'h45 : e.alu.ms_op = ring_pkg::ms_mul_s;
		8'h46 : e.alu.ms_op = ring_pkg::ms_shl_u;
		8'h47 : e.alu.ms_op = ring_pkg::ms_shl_s;
		default : ;  // add_u, mul_u, cpy are all zero
	endcase
	case (b)
		8'h30, 8'h4c : m = 8'b00000_100;  // word reads
		8'h31 : m = 8'b01100_100;
		8'h32 : m = 8'b01000_100;
		8'h33 : m = 8'b00110_100;
		8'h34 : m = 8'b00010_100;
		8'h35, 8'h4e : m = 8'b10000_100;  // pc relative reads
		8'h36 : m = 8'b11100_100;
		8'h37 : m = 8'b11000_100;
		8'h38 : m = 8'b10110_100;
		8'h39 : m = 8'b10010_100;
		8'h3a, 8'h50 : m = 8'b00000_010;  // reg bus read
		8'h3b, 8'h4d : m = 8'b00001_000;
		8'h3c : m = 8'b01001_000;
		8'h3d : m = 8'b00011_000;
		8'h3e, 8'h51 : m = 8'b00000_001;  // reg bus write
		8'h4f : m = 8'b10001_000;
		default : m = '0;
	endcase
	{e.mem, e.mem_rd, e.reg_rd, e.reg_wr} = m;
	if (b inside {8'h4c, 8'h4d})
		e.im_mem = {24'h0, i8};  // unsigned offset
	if (b inside {8'h4e, 8'h4f})
		e.im_mem = {{24{i8[7]}}, i8};  // signed offset
	return e;
endfunction

`endif

// File: bench/tb_hive_op_data.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hive_op_data;

	`include "tb_decode_model.svh"

	localparam int cycles = 4000;  // random words after reset
	localparam int edge_limit = 200;  // ns allowed per clock edge

	logic clk_i, rst_i, clt_i, irq_i;
	logic [ring_pkg::alu_w-1:0] oc_i;
	logic op_er_o, mem_rd_o, reg_rd_o, reg_wr_o, imda_o;
	logic [ring_pkg::alu_w-1:0] im_alu_o;
	logic [ring_pkg::pc_w-1:0] im_mem_o;
	logic [ring_pkg::stk_w-1:0] a_sel_o, b_sel_o;
	ring_pkg::mem_ctl_t mem_ctl_o;
	ring_pkg::stk_ctl_t stk_ctl_o;
	ring_pkg::alu_ctl_t alu_ctl_o;
	logic [31:0] lfsr;  // stimulus state
	logic [7:0] kept[$];  // legal opcode bytes
	dec_out_t want;  // expected at next fall

	hive_op_data u_hive_op_data (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.clt_i(clt_i),
		.irq_i(irq_i),
		.oc_i(oc_i),
		.op_er_o(op_er_o),
		.im_alu_o(im_alu_o),
		.im_mem_o(im_mem_o),
		.mem_ctl_o(mem_ctl_o),
		.mem_rd_o(mem_rd_o),
		.reg_rd_o(reg_rd_o),
		.reg_wr_o(reg_wr_o),
		.a_sel_o(a_sel_o),
		.b_sel_o(b_sel_o),
		.stk_ctl_o(stk_ctl_o),
		.imda_o(imda_o),
		.alu_ctl_o(alu_ctl_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;  // 100 ns period
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic wait_fall();
		int t;
		t = 0;
		while (clk_i !== 1'b1 && t < edge_limit) begin
			#1;
			t++;
		end
		while (clk_i !== 1'b0 && t < edge_limit) begin
			#1;
			t++;
		end
		if (t >= edge_limit) begin
			$display("Finished with errors");
			$fatal(1, "clock stopped toggling");
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			$display("Finished with errors");
			$fatal(1, "decoder output differs from model");
		end
	endtask

	// outputs are stable between rising edges
	task automatic check_all();
		check_val("alu_ctl_o", 32'(alu_ctl_o), 32'(want.alu));
		check_val("im_alu_o", im_alu_o, want.im_alu);
		check_val("imda_o", 32'(imda_o), 32'(want.imda));
		check_val("a_sel_o", 32'(a_sel_o), 32'(want.a_sel));
		check_val("b_sel_o", 32'(b_sel_o), 32'(want.b_sel));
		check_val("mem_ctl_o", 32'(mem_ctl_o), 32'(want.mem));
		check_val("mem_rd_o", 32'(mem_rd_o), 32'(want.mem_rd));
		check_val("reg_rd_o", 32'(reg_rd_o), 32'(want.reg_rd));
		check_val("reg_wr_o", 32'(reg_wr_o), 32'(want.reg_wr));
		check_val("im_mem_o", im_mem_o, want.im_mem);
		check_val("stk_ctl_o", 32'(stk_ctl_o), 32'(want.stk));
		check_val("op_er_o", 32'(op_er_o), 32'(want.op_er));
	endtask

	task automatic drive_word();
		logic [31:0] sel, hi, idx, raw, f;
		take_bits(2, sel);  // 3 in 4 from table
		take_bits(24, hi);
		if (sel != 0) begin
			take_bits(7, idx);
			raw = 32'(kept[idx % kept.size()]);
		end else begin
			take_bits(8, raw);  // any byte, often illegal
		end
		oc_i = {hi[23:0], raw[7:0]};
		take_bits(4, f);
		clt_i = (f == 0);  // about 1 in 16
		take_bits(4, f);
		irq_i = (f == 0);
		want = predict(oc_i, clt_i, irq_i);  // seen at next rise
	endtask

	initial begin
		int n;
		rst_i = 1'b1;
		clt_i = 1'b0;
		irq_i = 1'b0;
		oc_i = '0;
		lfsr = 32'h1dbf26de;
		want = '0;  // reset value
		for (n = 0; n < 256; n++) begin
			if (kept_op(8'(n)))
				kept.push_back(8'(n));
		end
		for (n = 0; n < 3; n++) begin
			wait_fall();
			check_all();  // held in reset
		end
		rst_i = 1'b0;
		want = predict(oc_i, clt_i, irq_i);  // nop word, still all zero
		for (n = 0; n < cycles; n++) begin
			wait_fall();
			check_all();
			drive_word();
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/hive_op_data.sv
`timescale 1ns/1ps
`default_nettype none

module hive_op_data (
	input wire clk_i,  // core clock
	input wire rst_i,  // async, active high
	input wire clt_i,  // clear thread
	input wire irq_i,  // interrupt
	input wire [ring_pkg::alu_w-1:0] oc_i,  // opcode word
	output logic op_er_o,  // 1=illegal opcode
	output logic [ring_pkg::alu_w-1:0] im_alu_o,  // alu immediate
	output logic [ring_pkg::pc_w-1:0] im_mem_o,  // mem immediate
	output ring_pkg::mem_ctl_t mem_ctl_o,
	output logic mem_rd_o,
	output logic reg_rd_o,
	output logic reg_wr_o,
	output logic [ring_pkg::stk_w-1:0] a_sel_o,  // a data selector
	output logic [ring_pkg::stk_w-1:0] b_sel_o,  // b data selector
	output ring_pkg::stk_ctl_t stk_ctl_o,
	output logic imda_o,  // 1=im replaces b data
	output ring_pkg::alu_ctl_t alu_ctl_o
);

	// three decoders see the same word, all register their result once
	op_alu_dec u_alu (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.oc_i(oc_i),
		.clt_i(clt_i),
		.irq_i(irq_i),
		.alu_ctl_o(alu_ctl_o),
		.im_alu_o(im_alu_o),
		.imda_o(imda_o),
		.a_sel_o(a_sel_o),
		.b_sel_o(b_sel_o)
	);

	op_mem_dec u_mem (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.oc_i(oc_i),
		.clt_i(clt_i),  // gates strobes
		.irq_i(irq_i),
		.mem_ctl_o(mem_ctl_o),
		.mem_rd_o(mem_rd_o),
		.reg_rd_o(reg_rd_o),
		.reg_wr_o(reg_wr_o),
		.im_mem_o(im_mem_o)
	);

	op_flow_dec u_flow (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.oc_i(oc_i),
		.clt_i(clt_i),
		.irq_i(irq_i),
		.stk_ctl_o(stk_ctl_o),
		.op_er_o(op_er_o)
	);

endmodule

`default_nettype wire

// File: hw/op_flow_dec.sv
`timescale 1ns/1ps
`default_nettype none

module op_flow_dec (
	input wire clk_i,  // core clock
	input wire rst_i,  // async, active high
	input wire [ring_pkg::alu_w-1:0] oc_i,  // opcode word
	input wire clt_i,  // clear thread
	input wire irq_i,  // interrupt
	output ring_pkg::stk_ctl_t stk_ctl_o,
	output logic op_er_o  // 1=illegal opcode
);

	ring_pkg::opcode_t oc;
	logic [ring_pkg::stk_w-1:0] oc_sa, oc_sb;
	logic oc_pa, oc_pb;
	logic [ring_pkg::byt_w-1:0] oc_im8_lo;  // stack mask
	ring_pkg::stk_ctl_t st;  // next stack control
	logic err;

	assign oc = ring_pkg::opcode_t'(oc_i[ring_pkg::oc_lsb +: ring_pkg::byt_w]);
	assign oc_sa = oc_i[ring_pkg::sa_lsb +: ring_pkg::stk_w];
	assign oc_sb = oc_i[ring_pkg::sb_lsb +: ring_pkg::stk_w];
	assign oc_pa = oc_i[ring_pkg::pa_bit];
	assign oc_pb = oc_i[ring_pkg::pb_bit];
	assign oc_im8_lo = oc_i[ring_pkg::im8_lo_lsb +: ring_pkg::byt_w];

	always_comb begin
		st = '0;  // no clear, pop or push
		st.sa = oc_sa;  // opcode directs
		st.sb = oc_sb;
		st.pa = oc_pa;
		st.pb = oc_pb;
		err = 1'b0;
		if (clt_i) begin
			st.cls = '1;  // wipe every stack
			st.pa = 1'b0;
			st.pb = 1'b0;
		end else if (irq_i) begin
			st.psh = 1'b1;  // pc goes to top stack
			st.sa = ring_pkg::stk_w'(ring_pkg::stacks - 1);
			st.pa = 1'b0;
			st.pb = 1'b0;
		end else begin
			case (oc) inside
				ring_pkg::op_nop, ring_pkg::op_hlt,
				ring_pkg::op_jmp_8, ring_pkg::op_jmp_16, ring_pkg::op_jmp_24 : begin
					st.pa = 1'b0;  // fields hold im bits
					st.pb = 1'b0;
				end
				ring_pkg::op_pop : begin
					st.pop = oc_im8_lo;  // pop by mask
					st.pa = 1'b0;
					st.pb = 1'b0;
				end
				ring_pkg::op_cls : begin
					st.cls = oc_im8_lo;  // clear by mask
					st.pa = 1'b0;
					st.pb = 1'b0;
				end
				ring_pkg::op_jmp, ring_pkg::op_gto, ring_pkg::op_irt : ;  // pops follow word
				ring_pkg::op_jsb, ring_pkg::op_gsb, ring_pkg::op_pcr,
				ring_pkg::op_jsb_8 : st.psh = 1'b1;  // pc pushed
				[ring_pkg::op_add_u : ring_pkg::op_xor],
				[ring_pkg::op_add_8u : ring_pkg::op_xor_8],
				[ring_pkg::op_add_16s : ring_pkg::op_xor_16] : st.psh = 1'b1;  // alu result
				[ring_pkg::op_mem_r : ring_pkg::op_reg_r],
				ring_pkg::op_mem_8r, ring_pkg::op_mem_i8r,
				ring_pkg::op_reg_8r : st.psh = 1'b1;  // read data
				[ring_pkg::op_mem_w : ring_pkg::op_reg_w],
				ring_pkg::op_mem_8w, ring_pkg::op_mem_i8w,
				ring_pkg::op_reg_8w : ;  // writes only consume
				default : err = 1'b1;  // unnamed byte
			endcase
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			stk_ctl_o <= '0;
			op_er_o <= 1'b0;
		end else begin
			stk_ctl_o <= st;
			op_er_o <= err;
		end
	end

endmodule

`default_nettype wire

// File: hw/op_mem_dec.sv
`timescale 1ns/1ps
`default_nettype none

module op_mem_dec (
	input wire clk_i,  // core clock
	input wire rst_i,  // async, active high
	input wire [ring_pkg::alu_w-1:0] oc_i,  // opcode word
	input wire clt_i,  // clear thread
	input wire irq_i,  // interrupt
	output ring_pkg::mem_ctl_t mem_ctl_o,
	output logic mem_rd_o,  // 1=mem read
	output logic reg_rd_o,  // 1=reg bus read
	output logic reg_wr_o,  // 1=reg bus write
	output logic [ring_pkg::pc_w-1:0] im_mem_o  // address offset
);

	ring_pkg::opcode_t oc;
	logic [ring_pkg::byt_w-1:0] oc_im8;
	logic [ring_pkg::pc_w-1:0] im8_zx, im8_sx;
	ring_pkg::mem_ctl_t ctl;  // next mem control
	logic rd, rrd, rwr;  // next strobes
	logic [ring_pkg::pc_w-1:0] im;

	assign oc = ring_pkg::opcode_t'(oc_i[ring_pkg::oc_lsb +: ring_pkg::byt_w]);
	assign oc_im8 = oc_i[ring_pkg::im8_lsb +: ring_pkg::byt_w];
	assign im8_zx = {{(ring_pkg::pc_w - ring_pkg::byt_w){1'b0}}, oc_im8};
	assign im8_sx = {{(ring_pkg::pc_w - ring_pkg::byt_w){oc_im8[ring_pkg::byt_w-1]}}, oc_im8};

	always_comb begin
		ctl = '0;  // word access, no lit
		rd = 1'b0;
		rrd = 1'b0;
		rwr = 1'b0;
		im = '0;
		// the opcode of a cleared or interrupted thread must not touch memory
		if (!(clt_i || irq_i)) begin
			ctl.wr = oc inside {[ring_pkg::op_mem_w : ring_pkg::op_mem_wb],
				ring_pkg::op_mem_8w, ring_pkg::op_mem_i8w};
			ctl.hlf = oc inside {ring_pkg::op_mem_wh, ring_pkg::op_mem_rhs,
				ring_pkg::op_mem_rhu, ring_pkg::op_lit_hs, ring_pkg::op_lit_hu};
			ctl.byt = oc inside {ring_pkg::op_mem_wb, ring_pkg::op_mem_rbs,
				ring_pkg::op_mem_rbu, ring_pkg::op_lit_bs, ring_pkg::op_lit_bu};
			ctl.sgn = oc inside {ring_pkg::op_mem_rhs, ring_pkg::op_mem_rbs,
				ring_pkg::op_lit_hs, ring_pkg::op_lit_bs};
			ctl.lit = oc inside {[ring_pkg::op_lit : ring_pkg::op_lit_bu],
				ring_pkg::op_mem_i8r, ring_pkg::op_mem_i8w};  // pc relative
			rd = oc inside {[ring_pkg::op_mem_r : ring_pkg::op_lit_bu],
				ring_pkg::op_mem_8r, ring_pkg::op_mem_i8r};
			rrd = oc inside {ring_pkg::op_reg_r, ring_pkg::op_reg_8r};
			rwr = oc inside {ring_pkg::op_reg_w, ring_pkg::op_reg_8w};
			if (oc inside {ring_pkg::op_mem_8r, ring_pkg::op_mem_8w}) begin
				im = im8_zx;  // unsigned offset
			end else if (oc inside {ring_pkg::op_mem_i8r, ring_pkg::op_mem_i8w}) begin
				im = im8_sx;  // signed offset from pc
			end
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			mem_ctl_o <= '0;
			mem_rd_o <= 1'b0;
			reg_rd_o <= 1'b0;
			reg_wr_o <= 1'b0;
			im_mem_o <= '0;
		end else begin
			mem_ctl_o <= ctl;
			mem_rd_o <= rd;
			reg_rd_o <= rrd;
			reg_wr_o <= rwr;
			im_mem_o <= im;
		end
	end

endmodule

`default_nettype wire

// File: hw/op_alu_dec.sv
`timescale 1ns/1ps
`default_nettype none

module op_alu_dec (
	input wire clk_i,  // core clock
	input wire rst_i,  // async, active high
	input wire [ring_pkg::alu_w-1:0] oc_i,  // opcode word
	input wire clt_i,  // clear thread
	input wire irq_i,  // interrupt
	output ring_pkg::alu_ctl_t alu_ctl_o,
	output logic [ring_pkg::alu_w-1:0] im_alu_o,  // alu immediate
	output logic imda_o,  // 1=im replaces b data
	output logic [ring_pkg::stk_w-1:0] a_sel_o,  // a data selector
	output logic [ring_pkg::stk_w-1:0] b_sel_o  // b data selector
);

	ring_pkg::opcode_t oc;
	logic [ring_pkg::stk_w-1:0] oc_sa, oc_sb;
	logic [ring_pkg::byt_w-1:0] oc_im8;
	logic [ring_pkg::hlf_w-1:0] oc_im16;
	logic [ring_pkg::alu_w-1:0] im8_sx, im16_sx;  // sign extended immediates
	ring_pkg::alu_ctl_t ctl;  // next alu control
	logic imm8, imm16;  // immediate alu forms
	logic imreg;  // register bus im address

	assign oc = ring_pkg::opcode_t'(oc_i[ring_pkg::oc_lsb +: ring_pkg::byt_w]);
	assign oc_sa = oc_i[ring_pkg::sa_lsb +: ring_pkg::stk_w];
	assign oc_sb = oc_i[ring_pkg::sb_lsb +: ring_pkg::stk_w];
	assign oc_im8 = oc_i[ring_pkg::im8_lsb +: ring_pkg::byt_w];
	assign oc_im16 = oc_i[ring_pkg::im16_lsb +: ring_pkg::hlf_w];
	assign im8_sx = {{(ring_pkg::alu_w - ring_pkg::byt_w){oc_im8[ring_pkg::byt_w-1]}}, oc_im8};
	assign im16_sx = {{(ring_pkg::alu_w - ring_pkg::hlf_w){oc_im16[ring_pkg::hlf_w-1]}}, oc_im16};

	always_comb begin
		ctl = '0;  // logical path, cpy
		imm8 = 1'b0;
		imm16 = 1'b0;
		imreg = 1'b0;
		if (!clt_i && irq_i) begin
			ctl.pc_sel = 1'b1;  // irq pushes pc
		end else if (!clt_i) begin
			imm8 = oc inside {[ring_pkg::op_add_8u : ring_pkg::op_xor_8]};
			imm16 = oc inside {[ring_pkg::op_add_16s : ring_pkg::op_xor_16]};
			imreg = oc inside {ring_pkg::op_reg_8r, ring_pkg::op_reg_8w};
			case (oc)
				ring_pkg::op_add_u, ring_pkg::op_add_us, ring_pkg::op_add_su, ring_pkg::op_add_s,
				ring_pkg::op_sub_u, ring_pkg::op_sub_us, ring_pkg::op_sub_su, ring_pkg::op_sub_s,
				ring_pkg::op_sbr_u, ring_pkg::op_sbr_us, ring_pkg::op_sbr_su,
				ring_pkg::op_sbr_s : begin
					ctl.as_sel = 1'b1;
					ctl.as_op = ring_pkg::as_op_t'(oc_i[ring_pkg::oc_lsb +: 4]);  // low nibble
				end
				ring_pkg::op_mul_u, ring_pkg::op_mul_us, ring_pkg::op_mul_su,
				ring_pkg::op_mul_s : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_op_t'({1'b0, oc_i[ring_pkg::oc_lsb +: 2]});
				end
				ring_pkg::op_shl_u, ring_pkg::op_shl_s, ring_pkg::op_rol, ring_pkg::op_pow : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_op_t'({1'b1, oc_i[ring_pkg::oc_lsb +: 2]});
				end
				ring_pkg::op_cpy : ctl.lg_op = ring_pkg::lg_cpy;
				ring_pkg::op_not : ctl.lg_op = ring_pkg::lg_not;
				ring_pkg::op_and, ring_pkg::op_and_8, ring_pkg::op_and_16 : ctl.lg_op = ring_pkg::lg_and;
				ring_pkg::op_orr, ring_pkg::op_orr_8, ring_pkg::op_orr_16 : ctl.lg_op = ring_pkg::lg_orr;
				ring_pkg::op_xor, ring_pkg::op_xor_8, ring_pkg::op_xor_16 : ctl.lg_op = ring_pkg::lg_xor;
				ring_pkg::op_add_8u : begin
					ctl.as_sel = 1'b1;
					ctl.as_op = ring_pkg::as_add_u;
				end
				ring_pkg::op_add_8s, ring_pkg::op_add_16s : begin
					ctl.as_sel = 1'b1;
					ctl.as_op = ring_pkg::as_add_s;
				end
				ring_pkg::op_sub_8u : begin
					ctl.as_sel = 1'b1;
					ctl.as_op = ring_pkg::as_sub_u;
				end
				ring_pkg::op_sub_8s : begin
					ctl.as_sel = 1'b1;
					ctl.as_op = ring_pkg::as_sub_s;
				end
				ring_pkg::op_mul_8u : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_mul_u;
				end
				ring_pkg::op_mul_8s : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_mul_s;
				end
				ring_pkg::op_shl_8u : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_shl_u;
				end
				ring_pkg::op_shl_8s : begin
					ctl.ms_sel = 1'b1;
					ctl.ms_op = ring_pkg::ms_shl_s;
				end
				ring_pkg::op_jsb, ring_pkg::op_gsb, ring_pkg::op_pcr,
				ring_pkg::op_jsb_8 : ctl.pc_sel = 1'b1;  // return pc to stack
				default : ;  // alu idle for mem, flow and bad ops
			endcase
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			alu_ctl_o <= '0;
			im_alu_o <= '0;
			imda_o <= 1'b0;
			a_sel_o <= '0;
			b_sel_o <= '0;
		end else begin
			alu_ctl_o <= ctl;
			im_alu_o <= imm16 ? im16_sx : im8_sx;  // im8 unless 16 bit form
			imda_o <= imm8 | imm16 | imreg;  // im => b
			a_sel_o <= (imm8 | imm16) ? oc_sb : oc_sa;  // b => a for im alu
			b_sel_o <= oc_sb;
		end
	end

endmodule

`default_nettype wire

// File: hw/ring_pkg.sv
`default_nettype none

package ring_pkg;

	// widths
	localparam int alu_w = 32;  // data and opcode word
	localparam int pc_w = 32;  // pc and memory address
	localparam int stacks = 8;  // stacks per thread
	localparam int stk_w = 3;  // stack index
	localparam int byt_w = 8;  // byte
	localparam int hlf_w = 16;  // half word

	// opcode word fields, bit positions
	localparam int oc_lsb = 0;  // opcode byte
	localparam int sa_lsb = 8;  // stack a index
	localparam int pa_bit = 11;  // pop a
	localparam int sb_lsb = 12;  // stack b index
	localparam int pb_bit = 15;  // pop b
	localparam int im8_lo_lsb = 8;  // stack mask for pop / cls
	localparam int im8_lsb = 16;  // 8 bit immediate
	localparam int im16_lsb = 16;  // 16 bit immediate

	// one 16 value block per class, classes may run into a second block
	// ranges inside a class are contiguous, the decoders use them as such
	typedef enum logic [7:0] {
		// control
		op_nop = 8'h00,
		op_hlt = 8'h01,
		op_pop = 8'h02,  // pop by mask
		op_cls = 8'h03,  // clear by mask
		op_jmp_8 = 8'h04,  // unconditional, im offset
		op_jmp_16 = 8'h05,
		op_jmp_24 = 8'h06,
		op_jmp = 8'h07,  // relative, offset from stack
		op_gto = 8'h08,  // absolute, from stack
		op_irt = 8'h09,  // return from irq
		op_jsb = 8'h0a,  // pushes return pc
		op_gsb = 8'h0b,
		op_pcr = 8'h0c,  // read pc
		// register alu, add/sub order matches as_op_t
		op_add_u = 8'h10,
		op_add_us = 8'h11,
		op_add_su = 8'h12,
		op_add_s = 8'h13,
		op_sub_u = 8'h14,
		op_sub_us = 8'h15,
		op_sub_su = 8'h16,
		op_sub_s = 8'h17,
		op_sbr_u = 8'h18,
		op_sbr_us = 8'h19,
		op_sbr_su = 8'h1a,
		op_sbr_s = 8'h1b,
		op_mul_u = 8'h1c,  // low 2 bits give mul variant
		op_mul_us = 8'h1d,
		op_mul_su = 8'h1e,
		op_mul_s = 8'h1f,
		op_shl_u = 8'h20,  // low 2 bits give shift variant
		op_shl_s = 8'h21,
		op_rol = 8'h22,
		op_pow = 8'h23,
		op_cpy = 8'h24,
		op_not = 8'h25,
		op_and = 8'h26,
		op_orr = 8'h27,
		op_xor = 8'h28,
		// memory and register bus, reads first
		op_mem_r = 8'h30,
		op_mem_rhs = 8'h31,
		op_mem_rhu = 8'h32,
		op_mem_rbs = 8'h33,
		op_mem_rbu = 8'h34,
		op_lit = 8'h35,  // literal follows opcode
		op_lit_hs = 8'h36,
		op_lit_hu = 8'h37,
		op_lit_bs = 8'h38,
		op_lit_bu = 8'h39,
		op_reg_r = 8'h3a,
		op_mem_w = 8'h3b,
		op_mem_wh = 8'h3c,
		op_mem_wb = 8'h3d,
		op_reg_w = 8'h3e,
		// 8 bit immediate, alu ops first
		op_add_8u = 8'h40,
		op_add_8s = 8'h41,
		op_sub_8u = 8'h42,
		op_sub_8s = 8'h43,
		op_mul_8u = 8'h44,
		op_mul_8s = 8'h45,
		op_shl_8u = 8'h46,
		op_shl_8s = 8'h47,
		op_and_8 = 8'h48,
		op_orr_8 = 8'h49,
		op_xor_8 = 8'h4a,
		op_jsb_8 = 8'h4b,
		op_mem_8r = 8'h4c,  // unsigned offset
		op_mem_8w = 8'h4d,
		op_mem_i8r = 8'h4e,  // signed literal offset
		op_mem_i8w = 8'h4f,
		op_reg_8r = 8'h50,  // reg address from im
		op_reg_8w = 8'h51,
		// 16 bit immediate
		op_add_16s = 8'h60,
		op_and_16 = 8'h61,
		op_orr_16 = 8'h62,
		op_xor_16 = 8'h63
	} opcode_t;

	// logical unit
	typedef enum logic [3:0] {
		lg_cpy = 4'd0,
		lg_not = 4'd1,
		lg_and = 4'd2,
		lg_orr = 4'd3,
		lg_xor = 4'd4
	} lg_op_t;

	// add/sub unit, u/s per operand a then b
	typedef enum logic [3:0] {
		as_add_u, as_add_us, as_add_su, as_add_s,
		as_sub_u, as_sub_us, as_sub_su, as_sub_s,
		as_sbr_u, as_sbr_us, as_sbr_su, as_sbr_s  // sbr is b - a
	} as_op_t;

	// mult/shift unit
	typedef enum logic [2:0] {
		ms_mul_u, ms_mul_us, ms_mul_su, ms_mul_s,
		ms_shl_u, ms_shl_s, ms_rol, ms_pow
	} ms_op_t;

	typedef struct packed {
		logic as_sel;  // 1=add/sub result
		logic ms_sel;  // 1=mult/shift result
		logic pc_sel;  // 1=pc result
		lg_op_t lg_op;
		as_op_t as_op;
		ms_op_t ms_op;
	} alu_ctl_t;

	typedef struct packed {
		logic lit;  // address from pc
		logic hlf;
		logic sgn;  // sign extend read
		logic byt;
		logic wr;
	} mem_ctl_t;

	typedef struct packed {
		logic [stacks-1:0] cls;  // per stack clear
		logic [stacks-1:0] pop;  // per stack pop
		logic [stk_w-1:0] sa;
		logic [stk_w-1:0] sb;
		logic pa;  // pop sa
		logic pb;  // pop sb
		logic psh;  // push to sa
	} stk_ctl_t;

endpackage

`default_nettype wire
